// File: cpu4_pkg.sv
`default_nettype none

package cpu4_pkg;

  typedef logic [11:0] opcode_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [7:0]  addr_t;

  // opcode patterns, compared against the fixed upper bits only
  localparam logic [7:0] OP_ADD_RQ = 8'hA8;
  localparam logic [5:0] OP_ADD_RI = 6'b110000;
  localparam logic [5:0] OP_LD_RI  = 6'b111000;
  localparam logic [3:0] OP_LD_XE  = 4'hB;
  localparam logic [3:0] OP_LD_YE  = 4'h8;
  localparam logic [7:0] OP_SET_F  = 8'hF4;
  localparam logic [7:0] OP_RST_F  = 8'hF5;

  // r / q operand codes
  localparam logic [1:0] SEL_A  = 2'd0;
  localparam logic [1:0] SEL_B  = 2'd1;
  localparam logic [1:0] SEL_MX = 2'd2;
  localparam logic [1:0] SEL_MY = 2'd3;

  // bit positions in the flag nibble
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_D = 2;
  localparam int FLAG_I = 3;

  localparam int BUF_DEPTH = 4;
  localparam int CYCLE_LEN = 7;

  // phases within one instruction cycle
  localparam logic [2:0] PH_DECODE = 3'd0;
  localparam logic [2:0] PH_READ   = 3'd2;
  localparam logic [2:0] PH_ALU    = 3'd4;
  localparam logic [2:0] PH_WRITE  = 3'(CYCLE_LEN - 1);

  // first four values line up with the operand codes
  typedef enum logic [2:0] {
    DEST_A,
    DEST_B,
    DEST_MX,
    DEST_MY,
    DEST_X,
    DEST_Y,
    DEST_F,
    DEST_NONE
  } dest_t;

endpackage

`default_nettype wire

// File: instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  cpu4_pkg::opcode_t instr_opcode,
  input  logic              buf_pop,
  output logic              buf_valid,
  output cpu4_pkg::opcode_t buf_opcode,
  output logic              credit_return
);
  import cpu4_pkg::*;

  opcode_t                        mem [BUF_DEPTH];
  logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(BUF_DEPTH+1)-1:0] count;
  logic                           push;
  logic                           pop;

  assign push = instr_valid && (count != BUF_DEPTH);
  assign pop  = buf_pop && (count != 0);

  assign buf_valid     = (count != 0);
  assign buf_opcode    = mem[rd_ptr];
  // one credit back for every opcode handed out
  assign credit_return = pop;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= instr_opcode;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // sender must never run out of credits and still push
  assert property (@(posedge clk) disable iff (!rst_n) instr_valid |-> count < BUF_DEPTH)
    else $error("instr_buffer: push while full");

  assert property (@(posedge clk) disable iff (!rst_n) buf_pop |-> buf_valid)
    else $error("instr_buffer: pop while empty");

endmodule

`default_nettype wire

// File: cycle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       timer_start,
  output logic [2:0] phase,
  output logic       cycle_done
);
  import cpu4_pkg::*;

  logic running;

  assign cycle_done = running && (phase == 3'(CYCLE_LEN - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      phase   <= PH_DECODE;
    end else if (timer_start) begin
      running <= 1'b1;
      phase   <= PH_DECODE;
    end else if (cycle_done) begin
      // park at phase 0 until the next start
      running <= 1'b0;
      phase   <= PH_DECODE;
    end else if (running) begin
      phase <= phase + 3'd1;
    end
  end

  // the FSM only starts a new cycle once the previous one is done
  assert property (@(posedge clk) disable iff (!rst_n) timer_start |-> !running)
    else $error("cycle_timer: start while running");

endmodule

`default_nettype wire

// File: nibble_alu.sv
`timescale 1ns/1ps
`default_nettype none

module nibble_alu (
  input  cpu4_pkg::nibble_t a,
  input  cpu4_pkg::nibble_t b,
  input  logic              decimal,
  output cpu4_pkg::nibble_t sum,
  output logic              carry,
  output logic              zero
);

  logic [4:0] raw;
  logic [4:0] adj;

  assign raw = {1'b0, a} + {1'b0, b};

  // decimal mode subtracts ten, non-BCD inputs included
  always_comb begin
    if (decimal && raw >= 5'd10) begin
      adj   = raw - 5'd10;
      carry = 1'b1;
    end else begin
      adj   = raw;
      carry = raw[4];
    end
  end

  assign sum  = adj[3:0];
  assign zero = (adj[3:0] == 4'h0);

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [1:0]        sel_r,
  input  logic [1:0]        sel_q,
  input  logic              reg_we,
  input  logic [1:0]        reg_wsel,
  input  cpu4_pkg::nibble_t wdata,
  input  logic              x_we,
  input  logic              y_we,
  input  cpu4_pkg::addr_t   addr_wdata,
  input  logic              flags_we,
  input  cpu4_pkg::nibble_t flags_wdata,
  input  cpu4_pkg::nibble_t ram_rdata_x,
  input  cpu4_pkg::nibble_t ram_rdata_y,
  output cpu4_pkg::nibble_t rd_data_r,
  output cpu4_pkg::nibble_t rd_data_q,
  output cpu4_pkg::nibble_t flags,
  output cpu4_pkg::addr_t   x_addr,
  output cpu4_pkg::addr_t   y_addr
);
  import cpu4_pkg::*;

  nibble_t reg_a;
  nibble_t reg_b;

  function automatic nibble_t read_sel(input logic [1:0] sel, input nibble_t va,
                                       input nibble_t vb, input nibble_t vmx,
                                       input nibble_t vmy);
    case (sel)
      SEL_A:   read_sel = va;
      SEL_B:   read_sel = vb;
      SEL_MX:  read_sel = vmx;
      default: read_sel = vmy;
    endcase
  endfunction

  assign rd_data_r = read_sel(sel_r, reg_a, reg_b, ram_rdata_x, ram_rdata_y);
  assign rd_data_q = read_sel(sel_q, reg_a, reg_b, ram_rdata_x, ram_rdata_y);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a  <= '0;
      reg_b  <= '0;
      x_addr <= '0;
      y_addr <= '0;
      flags  <= '0;
    end else begin
      if (reg_we && reg_wsel == SEL_A) reg_a <= wdata;
      if (reg_we && reg_wsel == SEL_B) reg_b <= wdata;
      if (x_we) x_addr <= addr_wdata;
      if (y_we) y_addr <= addr_wdata;
      if (flags_we) flags <= flags_wdata;
    end
  end

  // memory destinations go to data_ram, never through reg_we
  assert property (@(posedge clk) disable iff (!rst_n)
    reg_we |-> (reg_wsel == SEL_A || reg_wsel == SEL_B))
    else $error("reg_file: register write with a memory code");

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic              clk,
  input  logic              ram_we,
  input  logic              ram_use_y,
  input  cpu4_pkg::addr_t   x_addr,
  input  cpu4_pkg::addr_t   y_addr,
  input  cpu4_pkg::nibble_t wdata,
  output cpu4_pkg::nibble_t rdata_x,
  output cpu4_pkg::nibble_t rdata_y
);
  import cpu4_pkg::*;

  nibble_t mem [256];
  addr_t   waddr;

  // single write port, pointed at by X or Y
  assign waddr = ram_use_y ? y_addr : x_addr;

  always_ff @(posedge clk) begin
    if (ram_we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata_x = mem[x_addr];
  assign rdata_y = mem[y_addr];

endmodule

`default_nettype wire

// File: exec_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module exec_fsm (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              buf_valid,
  input  cpu4_pkg::opcode_t buf_opcode,
  input  logic [2:0]        phase,
  input  logic              cycle_done,
  input  cpu4_pkg::nibble_t rd_data_r,
  input  cpu4_pkg::nibble_t rd_data_q,
  input  cpu4_pkg::nibble_t flags,
  input  cpu4_pkg::nibble_t alu_sum,
  input  logic              alu_carry,
  input  logic              alu_zero,
  output logic              buf_pop,
  output logic              timer_start,
  output logic [1:0]        sel_r,
  output logic [1:0]        sel_q,
  output cpu4_pkg::nibble_t alu_b,
  output logic              reg_we,
  output logic [1:0]        reg_wsel,
  output cpu4_pkg::nibble_t wdata,
  output logic              x_we,
  output logic              y_we,
  output cpu4_pkg::addr_t   addr_wdata,
  output logic              flags_we,
  output cpu4_pkg::nibble_t flags_wdata,
  output logic              ram_we,
  output logic              ram_use_y,
  output logic              retire_valid,
  output logic [11:0]       retire_pc,
  output cpu4_pkg::opcode_t retire_opcode,
  output cpu4_pkg::dest_t   retire_dest,
  output cpu4_pkg::nibble_t retire_data,
  output cpu4_pkg::nibble_t retire_flags
);
  import cpu4_pkg::*;

  typedef enum logic {IDLE, EXEC} state_t;
  typedef enum logic [2:0] {
    K_ADD_RQ, K_ADD_RI, K_LD_RI, K_LD_XE, K_LD_YE, K_SET_F, K_RST_F, K_NONE
  } kind_t;

  state_t      state;
  kind_t       kind_d;
  kind_t       kind_q;
  opcode_t     op_q;
  logic [1:0]  r_q;
  logic [1:0]  q_q;
  nibble_t     b_q;
  nibble_t     sum_q;
  logic        carry_q;
  logic        zero_q;
  logic [11:0] pc_q;
  logic        is_write;
  logic        to_mem;
  nibble_t     res;
  nibble_t     flags_add;

  always_comb begin
    if (buf_opcode[11:4] == OP_ADD_RQ)      kind_d = K_ADD_RQ;
    else if (buf_opcode[11:6] == OP_ADD_RI) kind_d = K_ADD_RI;
    else if (buf_opcode[11:6] == OP_LD_RI)  kind_d = K_LD_RI;
    else if (buf_opcode[11:8] == OP_LD_XE)  kind_d = K_LD_XE;
    else if (buf_opcode[11:8] == OP_LD_YE)  kind_d = K_LD_YE;
    else if (buf_opcode[11:4] == OP_SET_F)  kind_d = K_SET_F;
    else if (buf_opcode[11:4] == OP_RST_F)  kind_d = K_RST_F;
    else                                    kind_d = K_NONE;
  end

  assign buf_pop     = (state == IDLE) && buf_valid;
  assign timer_start = buf_pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      kind_q <= K_NONE;
      pc_q   <= '0;
    end else begin
      if (buf_pop) begin
        state  <= EXEC;
        kind_q <= kind_d;
      end else if (cycle_done) begin
        state <= IDLE;
      end
      if (retire_valid) begin
        pc_q <= pc_q + 12'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_pop) begin
      op_q <= buf_opcode;
      // ADD r,q keeps r in bits 3:2, the immediate forms in bits 5:4
      r_q  <= (kind_d == K_ADD_RQ) ? buf_opcode[3:2] : buf_opcode[5:4];
      q_q  <= buf_opcode[1:0];
    end
    if (state == EXEC && phase == PH_READ) begin
      b_q <= (kind_q == K_ADD_RQ) ? rd_data_q : op_q[3:0];
    end
    if (state == EXEC && phase == PH_ALU) begin
      sum_q   <= alu_sum;
      carry_q <= alu_carry;
      zero_q  <= alu_zero;
    end
  end

  assign sel_r = r_q;
  assign sel_q = q_q;
  assign alu_b = b_q;

  assign is_write = (state == EXEC) && (phase == PH_WRITE);
  assign to_mem   = (r_q == SEL_MX) || (r_q == SEL_MY);
  assign res      = (kind_q == K_LD_RI) ? op_q[3:0] : sum_q;

  // add updates C and Z while D and I pass through
  always_comb begin
    flags_add[FLAG_C] = carry_q;
    flags_add[FLAG_Z] = zero_q;
    flags_add[FLAG_D] = flags[FLAG_D];
    flags_add[FLAG_I] = flags[FLAG_I];
  end

  always_comb begin
    reg_we      = 1'b0;
    ram_we      = 1'b0;
    x_we        = 1'b0;
    y_we        = 1'b0;
    flags_we    = 1'b0;
    reg_wsel    = r_q;
    ram_use_y   = (r_q == SEL_MY);
    wdata       = res;
    addr_wdata  = op_q[7:0];
    flags_wdata = flags_add;
    retire_dest = DEST_NONE;
    retire_data = 4'h0;
    case (kind_q)
      K_ADD_RQ, K_ADD_RI, K_LD_RI: begin
        reg_we      = is_write && !to_mem;
        ram_we      = is_write && to_mem;
        flags_we    = is_write && (kind_q != K_LD_RI);
        retire_dest = dest_t'({1'b0, r_q});
        retire_data = res;
      end
      K_LD_XE: begin
        x_we        = is_write;
        retire_dest = DEST_X;
        retire_data = op_q[3:0];
      end
      K_LD_YE: begin
        y_we        = is_write;
        retire_dest = DEST_Y;
        retire_data = op_q[3:0];
      end
      K_SET_F: begin
        flags_wdata = flags | op_q[3:0];
        flags_we    = is_write;
        retire_dest = DEST_F;
        retire_data = flags | op_q[3:0];
      end
      K_RST_F: begin
        flags_wdata = flags & ~op_q[3:0];
        flags_we    = is_write;
        retire_dest = DEST_F;
        retire_data = flags & ~op_q[3:0];
      end
      default: begin
        // unknown opcodes retire without a write
      end
    endcase
  end

  assign retire_valid  = is_write;
  assign retire_pc     = pc_q;
  assign retire_opcode = op_q;
  assign retire_flags  = flags_we ? flags_wdata : flags;

  assert property (@(posedge clk) disable iff (!rst_n) retire_valid == cycle_done)
    else $error("exec_fsm: retire out of step with the timer");

  // nothing may disturb operand r between read and ALU phases
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == EXEC && phase == PH_READ) |-> ##2 (rd_data_r === $past(rd_data_r, 2)))
    else $error("exec_fsm: operand r changed before ALU phase");

endmodule

`default_nettype wire

// File: cpu4_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu4_core (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  cpu4_pkg::opcode_t instr_opcode,
  output logic              credit_return,
  output logic              retire_valid,
  output logic [11:0]       retire_pc,
  output cpu4_pkg::opcode_t retire_opcode,
  output cpu4_pkg::dest_t   retire_dest,
  output cpu4_pkg::nibble_t retire_data,
  output cpu4_pkg::nibble_t retire_flags
);
  import cpu4_pkg::*;

  logic       buf_valid;
  opcode_t    buf_opcode;
  logic       buf_pop;
  logic       timer_start;
  logic [2:0] phase;
  logic       cycle_done;
  logic [1:0] sel_r;
  logic [1:0] sel_q;
  nibble_t    rd_data_r;
  nibble_t    rd_data_q;
  nibble_t    flags;
  nibble_t    alu_b;
  nibble_t    alu_sum;
  logic       alu_carry;
  logic       alu_zero;
  logic       reg_we;
  logic [1:0] reg_wsel;
  nibble_t    wdata;
  logic       x_we;
  logic       y_we;
  addr_t      addr_wdata;
  logic       flags_we;
  nibble_t    flags_wdata;
  logic       ram_we;
  logic       ram_use_y;
  addr_t      x_addr;
  addr_t      y_addr;
  nibble_t    ram_rdata_x;
  nibble_t    ram_rdata_y;

  instr_buffer u_buf (
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr_opcode(instr_opcode),
    .buf_pop(buf_pop), .buf_valid(buf_valid), .buf_opcode(buf_opcode),
    .credit_return(credit_return)
  );

  cycle_timer u_timer (
    .clk(clk), .rst_n(rst_n), .timer_start(timer_start),
    .phase(phase), .cycle_done(cycle_done)
  );

  exec_fsm u_fsm (
    .clk(clk), .rst_n(rst_n),
    .buf_valid(buf_valid), .buf_opcode(buf_opcode),
    .phase(phase), .cycle_done(cycle_done),
    .rd_data_r(rd_data_r), .rd_data_q(rd_data_q), .flags(flags),
    .alu_sum(alu_sum), .alu_carry(alu_carry), .alu_zero(alu_zero),
    .buf_pop(buf_pop), .timer_start(timer_start),
    .sel_r(sel_r), .sel_q(sel_q), .alu_b(alu_b),
    .reg_we(reg_we), .reg_wsel(reg_wsel), .wdata(wdata),
    .x_we(x_we), .y_we(y_we), .addr_wdata(addr_wdata),
    .flags_we(flags_we), .flags_wdata(flags_wdata),
    .ram_we(ram_we), .ram_use_y(ram_use_y),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_opcode(retire_opcode), .retire_dest(retire_dest),
    .retire_data(retire_data), .retire_flags(retire_flags)
  );

  // operand a comes straight from the r read port
  nibble_alu u_alu (
    .a(rd_data_r), .b(alu_b), .decimal(flags[FLAG_D]),
    .sum(alu_sum), .carry(alu_carry), .zero(alu_zero)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n), .sel_r(sel_r), .sel_q(sel_q),
    .reg_we(reg_we), .reg_wsel(reg_wsel), .wdata(wdata),
    .x_we(x_we), .y_we(y_we), .addr_wdata(addr_wdata),
    .flags_we(flags_we), .flags_wdata(flags_wdata),
    .ram_rdata_x(ram_rdata_x), .ram_rdata_y(ram_rdata_y),
    .rd_data_r(rd_data_r), .rd_data_q(rd_data_q), .flags(flags),
    .x_addr(x_addr), .y_addr(y_addr)
  );

  data_ram u_ram (
    .clk(clk), .ram_we(ram_we), .ram_use_y(ram_use_y),
    .x_addr(x_addr), .y_addr(y_addr), .wdata(wdata),
    .rdata_x(ram_rdata_x), .rdata_y(ram_rdata_y)
  );

endmodule

`default_nettype wire

// File: tb_cpu4.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu4;
  import cpu4_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  opcode_t     instr_opcode;
  logic        credit_return;
  logic        retire_valid;
  logic [11:0] retire_pc;
  opcode_t     retire_opcode;
  dest_t       retire_dest;
  nibble_t     retire_data;
  nibble_t     retire_flags;

  // reference model state
  nibble_t     m_a;
  nibble_t     m_b;
  nibble_t     m_f;
  addr_t       m_x;
  addr_t       m_y;
  nibble_t     m_ram [256];
  logic [11:0] m_pc;

  opcode_t     op_q[$];
  string       name_q[$];
  int          credit_cyc[$];
  int          credits;
  int          cyc;
  int          last_ret;
  int          errors;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;
  string       test_name;
  logic [31:0] rng;

  cpu4_core uut (
    .clk(clk), .rst_n(rst_n),
    .instr_valid(instr_valid), .instr_opcode(instr_opcode),
    .credit_return(credit_return), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_opcode(retire_opcode),
    .retire_dest(retire_dest), .retire_data(retire_data),
    .retire_flags(retire_flags)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
  end

  function automatic nibble_t rand_nibble();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng[7:4];
  endfunction

  function automatic void add_ref(input nibble_t a, input nibble_t b, input logic dec,
                                  output nibble_t sum, output logic carry,
                                  output logic zero);
    logic [4:0] raw;
    raw = {1'b0, a} + {1'b0, b};
    carry = raw[4];
    // decimal mode takes ten off any sum of ten or more
    if (dec && raw >= 5'd10) begin
      raw = raw - 5'd10;
      carry = 1'b1;
    end
    sum = raw[3:0];
    zero = (sum == 4'h0);
  endfunction

  function automatic nibble_t read_ref(input logic [1:0] sel);
    case (sel)
      2'd0: return m_a;
      2'd1: return m_b;
      2'd2: return m_ram[m_x];
      default: return m_ram[m_y];
    endcase
  endfunction

  function automatic void write_ref(input logic [1:0] sel, input nibble_t v);
    case (sel)
      2'd0: m_a = v;
      2'd1: m_b = v;
      2'd2: m_ram[m_x] = v;
      default: m_ram[m_y] = v;
    endcase
  endfunction

  function automatic void exec_ref(input opcode_t op, output dest_t dest,
                                   output nibble_t data, output nibble_t flags);
    nibble_t    b;
    nibble_t    s;
    logic       c;
    logic       z;
    logic [1:0] r;
    dest = DEST_NONE;
    data = 4'h0;
    r = op[5:4];
    if (op[11:4] == 8'hA8 || op[11:6] == 6'b110000) begin
      if (op[11:4] == 8'hA8) begin
        r = op[3:2];
        b = read_ref(op[1:0]);
      end else begin
        b = op[3:0];
      end
      add_ref(read_ref(r), b, m_f[FLAG_D], s, c, z);
      write_ref(r, s);
      m_f[FLAG_C] = c;
      m_f[FLAG_Z] = z;
      dest = dest_t'({1'b0, r});
      data = s;
    end else if (op[11:6] == 6'b111000) begin
      write_ref(r, op[3:0]);
      dest = dest_t'({1'b0, r});
      data = op[3:0];
    end else if (op[11:8] == 4'hB) begin
      m_x = op[7:0];
      dest = DEST_X;
      data = op[3:0];
    end else if (op[11:8] == 4'h8) begin
      m_y = op[7:0];
      dest = DEST_Y;
      data = op[3:0];
    end else if (op[11:4] == 8'hF4) begin
      m_f = m_f | op[3:0];
      dest = DEST_F;
      data = m_f;
    end else if (op[11:4] == 8'hF5) begin
      m_f = m_f & ~op[3:0];
      dest = DEST_F;
      data = m_f;
    end
    flags = m_f;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_val(input string field, input logic [31:0] exp_v,
                           input logic [31:0] act_v, input string name);
    assert (act_v === exp_v)
      else begin
        $display("ERR %s %s expected %0h actual %0h", name, field, exp_v, act_v);
        errors++;
      end
  endtask

  task automatic check_retire();
    opcode_t op;
    string   name;
    dest_t   e_dest;
    nibble_t e_data;
    nibble_t e_flags;
    int      c;
    assert (op_q.size() > 0)
      else begin
        $display("retire of opcode %h seen with nothing outstanding", retire_opcode);
        errors++;
      end
    if (op_q.size() > 0) begin
      op = op_q.pop_front();
      name = name_q.pop_front();
      exec_ref(op, e_dest, e_data, e_flags);
      check_val("pc", m_pc, retire_pc, name);
      m_pc++;
      check_val("opcode", op, retire_opcode, name);
      check_val("dest", e_dest, retire_dest, name);
      check_val("data", e_data, retire_data, name);
      check_val("flags", e_flags, retire_flags, name);
      assert (credit_cyc.size() > 0)
        else begin
          $display("%s: retire without a matching credit_return", name);
          errors++;
        end
      if (credit_cyc.size() > 0) begin
        c = credit_cyc.pop_front();
        check_val("credit_to_retire_clocks", CYCLE_LEN, cyc - c, name);
      end
      if (last_ret >= 0) begin
        assert (cyc - last_ret >= CYCLE_LEN + 1)
          else begin
            $display("%s: two retires only %0d clocks apart", name, cyc - last_ret);
            errors++;
          end
      end
      last_ret = cyc;
    end
  endtask

  // outputs sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (credit_return === 1'b1) begin
        credits++;
        credit_cyc.push_back(cyc);
      end
      if (retire_valid === 1'b1) begin
        check_retire();
      end
    end
  end

  task automatic send(input opcode_t op);
    int waited;
    waited = 0;
    while (credits == 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 2000) begin
        abort("timed out waiting for a credit to send the next opcode");
      end
    end
    credits--;
    op_q.push_back(op);
    name_q.push_back(test_name);
    instr_valid = 1'b1;
    instr_opcode = op;
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (op_q.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 2000) begin
        abort("timed out waiting for issued opcodes to retire");
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    wait_idle();
    assert (credits == BUF_DEPTH && credit_cyc.size() == 0)
      else begin
        $display("%s: credits do not balance once every opcode retired", test_name);
        errors++;
      end
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s finished with no errors", test_name);
    end else begin
      tests_bad++;
      $display("test %s finished with %0d errors", test_name, errors - err_mark);
    end
  endtask

  initial begin
    addr_t xa;
    int    r;
    int    q;
    int    k;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr_opcode = '0;
    credits = BUF_DEPTH;
    cyc = 0;
    last_ret = -1;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    rng = 32'd25;
    m_a = '0;
    m_b = '0;
    m_f = '0;
    m_x = '0;
    m_y = '0;
    m_pc = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    begin_test("reset_quiet");
    repeat (10) begin
      @(negedge clk);
      assert (retire_valid === 1'b0 && credit_return === 1'b0)
        else begin
          $display("retire_valid or credit_return went high before any opcode was sent");
          errors++;
        end
    end
    @(posedge clk);
    #2;
    end_test();

    // LD X,e then LD Y,e at a different address
    begin_test("add_rq_bin");
    xa = {rand_nibble(), rand_nibble()};
    send({4'hB, xa});
    send({4'h8, xa ^ 8'h81});
    for (r = 0; r < 4; r++) begin
      for (q = 0; q < 4; q++) begin
        send({6'b111000, SEL_A, rand_nibble()});
        send({6'b111000, SEL_B, rand_nibble()});
        send({6'b111000, SEL_MX, rand_nibble()});
        send({6'b111000, SEL_MY, rand_nibble()});
        send({8'hA8, r[1:0], q[1:0]});
        // read a memory result back through A
        if (r >= 2) begin
          send({8'hA8, SEL_A, r[1:0]});
        end
      end
    end
    end_test();

    begin_test("add_ri_bin");
    for (k = 0; k < 12; k++) begin
      send({6'b110000, k[1:0], rand_nibble()});
    end
    // 9 + 7 wraps to zero
    send({6'b111000, SEL_B, 4'h9});
    send({6'b110000, SEL_B, 4'h7});
    end_test();

    begin_test("decimal");
    send({8'hF4, 4'h4});
    send({6'b111000, SEL_A, 4'h3});
    send({6'b111000, SEL_B, 4'h4});
    send({8'hA8, SEL_A, SEL_B});
    send({6'b111000, SEL_A, 4'h6});
    send({6'b110000, SEL_A, 4'h7});
    send({6'b111000, SEL_A, 4'h5});
    send({6'b110000, SEL_A, 4'h5});
    // non-BCD operands
    send({6'b111000, SEL_B, 4'hF});
    send({6'b110000, SEL_B, 4'hE});
    send({6'b111000, SEL_MX, 4'h9});
    send({8'hA8, SEL_MX, SEL_B});
    for (k = 0; k < 8; k++) begin
      send({8'hA8, rand_nibble()});
      send({6'b110000, k[1:0], rand_nibble()});
    end
    send({8'hF5, 4'h4});
    send({6'b111000, SEL_A, 4'h6});
    send({6'b110000, SEL_A, 4'h7});
    end_test();

    begin_test("credit_flow");
    send({6'b111000, SEL_A, 4'h1});
    for (k = 0; k < BUF_DEPTH; k++) begin
      send({6'b110000, SEL_A, 4'h1});
    end
    assert (credits == 0)
      else begin
        $display("sender still holds %0d credits with the buffer full", credits);
        errors++;
      end
    send({6'b110000, SEL_B, 4'h2});
    end_test();

    begin_test("timing");
    for (k = 0; k < 3; k++) begin
      send({6'b110000, SEL_B, rand_nibble()});
    end
    end_test();

    begin_test("unknown_op");
    send({6'b111000, SEL_A, 4'h5});
    send({6'b110000, SEL_A, 4'hB});
    send(12'h123);
    send(12'hFFF);
    send({8'hA8, SEL_A, SEL_B});
    end_test();

    $display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
cpu4_pkg.sv
instr_buffer.sv
cycle_timer.sv
nibble_alu.sv
reg_file.sv
data_ram.sv
exec_fsm.sv
cpu4_core.sv
tb_cpu4.sv

// File: Bender.yml
package:
  name: cpu4_core

sources:
  - cpu4_pkg.sv
  - instr_buffer.sv
  - cycle_timer.sv
  - nibble_alu.sv
  - reg_file.sv
  - data_ram.sv
  - exec_fsm.sv
  - cpu4_core.sv
  - target: test
    files:
      - tb_cpu4.sv
